// File: design/mpm_access_if.sv
`default_nettype none

interface mpm_access_if import mpm_pkg::*; #(
  parameter int WIDTH = 32,
  parameter int NUMVBNK = 8,
  parameter int NUMVROW = 64,
  localparam int BVB = $clog2(NUMVBNK),
  localparam int BVR = $clog2(NUMVROW)
) ();

  logic             bank_wr1;
  logic [BVB-1:0]   bank_wr1_bank;
  logic [BVR-1:0]   bank_wr1_row;
  logic [WIDTH-1:0] bank_wr1_data;
  logic             bank_wr2;
  logic [BVB-1:0]   bank_wr2_bank;
  logic [BVR-1:0]   bank_wr2_row;
  logic [WIDTH-1:0] bank_wr2_data;
  logic             cache_wr;
  logic [BVR-1:0]   cache_wr_row;
  logic [WIDTH-1:0] cache_wr_data;
  logic             rd1;
  logic [BVB-1:0]   rd1_bank;
  logic [BVR-1:0]   rd1_row;
  rd_src_e          rd1_src;
  logic             rd2;
  logic [BVB-1:0]   rd2_bank;
  logic [BVR-1:0]   rd2_row;
  rd_src_e          rd2_src;
  logic             evict_rd; // Uses cache read port 1.
  logic [BVR-1:0]   evict_row;

  modport map (
    output bank_wr1, bank_wr1_bank, bank_wr1_row, bank_wr1_data,
    output bank_wr2, bank_wr2_bank, bank_wr2_row, bank_wr2_data,
    output cache_wr, cache_wr_row, cache_wr_data,
    output rd1, rd1_bank, rd1_row, rd1_src, rd2, rd2_bank, rd2_row, rd2_src,
    output evict_rd, evict_row
  );

  modport mux (
    input bank_wr1, bank_wr1_bank, bank_wr1_row, bank_wr1_data,
    input bank_wr2, bank_wr2_bank, bank_wr2_row, bank_wr2_data,
    input cache_wr, cache_wr_row, cache_wr_data,
    input rd1, rd1_bank, rd1_row, rd1_src, rd2, rd2_bank, rd2_row, rd2_src,
    input evict_rd, evict_row
  );

endinterface

`default_nettype wire

// File: design/mpm_map_stage.sv
`default_nettype none

module mpm_map_stage import mpm_pkg::*; #(
  parameter int WIDTH = 32,
  parameter int NUMVBNK = 8,
  parameter int NUMVROW = 64,
  parameter int READ_DELAY = 2,
  localparam int BVB = $clog2(NUMVBNK),
  localparam int BVR = $clog2(NUMVROW)
) (
  input  wire              clk,
  input  wire              rst_n,
  input  wire              req_valid,
  output logic             req_ready,
  input  wire              rd_en1,
  input  wire  [BVB-1:0]   rd_bank1,
  input  wire  [BVR-1:0]   rd_row1,
  input  wire              rd_en2,
  input  wire  [BVB-1:0]   rd_bank2,
  input  wire  [BVR-1:0]   rd_row2,
  input  wire              wr_en1,
  input  wire  [BVB-1:0]   wr_bank1,
  input  wire  [BVR-1:0]   wr_row1,
  input  wire  [WIDTH-1:0] wr_data1,
  input  wire              wr_en2,
  input  wire  [BVB-1:0]   wr_bank2,
  input  wire  [BVR-1:0]   wr_row2,
  input  wire  [WIDTH-1:0] wr_data2,
  mpm_access_if.map        acc,
  input  wire  [WIDTH-1:0] evict_data
);

  localparam int CW = $clog2(READ_DELAY + 1);

  map_state_e     state;
  map_entry_t     map_q [NUMVROW];
  map_entry_t     ent_w1;
  map_entry_t     ent_w2;
  map_entry_t     ent_r1;
  map_entry_t     ent_r2;
  logic [CW-1:0]  wait_cnt;
  logic [BVB-1:0] evict_bank;
  logic [BVR-1:0] evict_row;
  logic           same_bank;
  logic           w1_main;
  logic           w1_cache;
  logic           hit_w1;
  logic           hit_w2;
  logic           evict_need;
  logic           evict_start;
  logic           evict_wr;
  logic           accept;
  rd_src_e        src1;
  rd_src_e        src2;

  assign ent_w1 = map_q[wr_row1];
  assign ent_w2 = map_q[wr_row2];
  assign ent_r1 = map_q[rd_row1];
  assign ent_r2 = map_q[rd_row2];

  assign same_bank = wr_en1 && wr_en2 && (wr_bank1 == wr_bank2);
  assign w1_main   = wr_en1 && !same_bank;
  assign w1_cache  = same_bank && (wr_row1 != wr_row2); // Same row keeps write 2 only.
  assign hit_w1    = ent_w1.valid && (ent_w1.bank == MAP_BANK_W'(wr_bank1));
  assign hit_w2    = ent_w2.valid && (ent_w2.bank == MAP_BANK_W'(wr_bank2));
  assign evict_need = w1_cache && ent_w1.valid && !hit_w1;

  assign req_ready   = (state == ST_RUN) && !(req_valid && evict_need);
  assign accept      = req_valid && req_ready;
  assign evict_start = (state == ST_RUN) && req_valid && evict_need;
  assign evict_wr    = (state == ST_EVICT_WR);

  assign src1 = (ent_r1.valid && ent_r1.bank == MAP_BANK_W'(rd_bank1)) ? SRC_CACHE : SRC_BANK;
  assign src2 = (ent_r2.valid && ent_r2.bank == MAP_BANK_W'(rd_bank2)) ? SRC_CACHE : SRC_BANK;

  always_ff @(posedge clk) begin
    if (!rst_n) begin
      state    <= ST_RUN;
      wait_cnt <= '0;
    end else begin
      case (state)
        ST_RUN: begin
          if (evict_start) begin
            state    <= ST_EVICT_RD;
            wait_cnt <= '0;
          end
        end
        ST_EVICT_RD: begin
          if (wait_cnt == CW'(READ_DELAY - 1)) begin // Cache word arrives next cycle.
            state <= ST_EVICT_WR;
          end else begin
            wait_cnt <= wait_cnt + 1'b1;
          end
        end
        ST_EVICT_WR: state <= ST_RUN;
        default:     state <= ST_RUN;
      endcase
    end
  end

  always_ff @(posedge clk) begin
    if (!rst_n) begin
      for (int i = 0; i < NUMVROW; i++) begin
        map_q[i] <= '0;
      end
    end else if (accept) begin
      if (wr_en2 && hit_w2) begin
        map_q[wr_row2].valid <= 1'b0; // Bank now holds the newest word.
      end
      if (w1_main && hit_w1) begin
        map_q[wr_row1].valid <= 1'b0;
      end
      if (w1_cache) begin
        map_q[wr_row1].valid <= 1'b1;
        map_q[wr_row1].bank  <= MAP_BANK_W'(wr_bank1);
      end
    end else if (evict_wr) begin
      map_q[evict_row].valid <= 1'b0;
    end
  end

  always_ff @(posedge clk) begin
    if (!rst_n) begin
      acc.bank_wr1 <= 1'b0;
      acc.bank_wr2 <= 1'b0;
      acc.cache_wr <= 1'b0;
      acc.rd1      <= 1'b0;
      acc.rd2      <= 1'b0;
      acc.evict_rd <= 1'b0;
    end else begin
      acc.bank_wr1 <= (accept && w1_main) || evict_wr;
      acc.bank_wr2 <= accept && wr_en2;
      acc.cache_wr <= accept && w1_cache;
      acc.rd1      <= accept && rd_en1;
      acc.rd2      <= accept && rd_en2;
      acc.evict_rd <= evict_start;
    end
  end

  always_ff @(posedge clk) begin
    acc.bank_wr1_bank <= evict_wr ? evict_bank : wr_bank1;
    acc.bank_wr1_row  <= evict_wr ? evict_row : wr_row1;
    acc.bank_wr1_data <= evict_wr ? evict_data : wr_data1;
    acc.bank_wr2_bank <= wr_bank2;
    acc.bank_wr2_row  <= wr_row2;
    acc.bank_wr2_data <= wr_data2;
    acc.cache_wr_row  <= wr_row1;
    acc.cache_wr_data <= wr_data1;
    acc.rd1_bank      <= rd_bank1;
    acc.rd1_row       <= rd_row1;
    acc.rd1_src       <= src1;
    acc.rd2_bank      <= rd_bank2;
    acc.rd2_row       <= rd_row2;
    acc.rd2_src       <= src2;
    acc.evict_row     <= wr_row1;
    if (evict_start) begin
      evict_row  <= wr_row1;
      evict_bank <= BVB'(ent_w1.bank); // Owner of the word being pushed out.
    end
  end

endmodule

`default_nettype wire

// File: design/mpm_pkg.sv
`default_nettype none

package mpm_pkg;

  localparam int MAP_BANK_W = 3; // Wide enough for up to 8 main banks.

  typedef enum logic [1:0] {
    ST_RUN,
    ST_EVICT_RD,
    ST_EVICT_WR
  } map_state_e;

  typedef enum logic {
    SRC_BANK,
    SRC_CACHE
  } rd_src_e;

  // One entry per row, naming the bank whose newest word sits in the cache.
  typedef struct packed {
    logic                  valid;
    logic [MAP_BANK_W-1:0] bank;
  } map_entry_t;

endpackage

`default_nettype wire

// File: design/mpm_port_mux.sv
`default_nettype none

module mpm_port_mux import mpm_pkg::*; #(
  parameter int WIDTH = 32,
  parameter int NUMVBNK = 8,
  parameter int NUMVROW = 64,
  parameter int READ_DELAY = 2,
  localparam int BVB = $clog2(NUMVBNK),
  localparam int BVR = $clog2(NUMVROW)
) (
  input  wire               clk,
  input  wire               rst_n,
  mpm_access_if.mux         acc,
  mpm_resp_if.source        resp,
  output logic [NUMVBNK-1:0] bank_we,
  output logic [BVR-1:0]    bank_waddr [NUMVBNK],
  output logic [WIDTH-1:0]  bank_wdata [NUMVBNK],
  output logic [NUMVBNK-1:0] bank_re1,
  output logic [NUMVBNK-1:0] bank_re2,
  output logic [BVR-1:0]    bank_raddr1,
  output logic [BVR-1:0]    bank_raddr2,
  input  wire  [WIDTH-1:0]  bank_rdata1 [NUMVBNK],
  input  wire  [WIDTH-1:0]  bank_rdata2 [NUMVBNK],
  output logic [1:0]        cache_we,
  output logic [BVR-1:0]    cache_waddr [2],
  output logic [WIDTH-1:0]  cache_wdata [2],
  output logic [1:0]        cache_re,
  output logic [BVR-1:0]    cache_raddr [2],
  input  wire  [WIDTH-1:0]  cache_rdata [2],
  output logic [WIDTH-1:0]  evict_data
);

  localparam int L = READ_DELAY - 1;

  logic [READ_DELAY-1:0] vld1_q;
  logic [READ_DELAY-1:0] vld2_q;
  logic [READ_DELAY-1:0] evict_q;
  logic [BVB-1:0]        bnk1_q [READ_DELAY];
  logic [BVB-1:0]        bnk2_q [READ_DELAY];
  rd_src_e               src1_q [READ_DELAY];
  rd_src_e               src2_q [READ_DELAY];

  always_comb begin
    for (int b = 0; b < NUMVBNK; b++) begin
      bank_we[b]  = (acc.bank_wr1 && acc.bank_wr1_bank == BVB'(b)) ||
                    (acc.bank_wr2 && acc.bank_wr2_bank == BVB'(b));
      bank_re1[b] = acc.rd1 && (acc.rd1_src == SRC_BANK) && (acc.rd1_bank == BVB'(b));
      bank_re2[b] = acc.rd2 && (acc.rd2_src == SRC_BANK) && (acc.rd2_bank == BVB'(b));
      if (acc.bank_wr2 && acc.bank_wr2_bank == BVB'(b)) begin // Write 2 wins the bank.
        bank_waddr[b] = acc.bank_wr2_row;
        bank_wdata[b] = acc.bank_wr2_data;
      end else begin
        bank_waddr[b] = acc.bank_wr1_row;
        bank_wdata[b] = acc.bank_wr1_data;
      end
    end
  end

  assign bank_raddr1 = acc.rd1_row;
  assign bank_raddr2 = acc.rd2_row;

  // Both cache copies take every write so each can serve one read port.
  assign cache_we    = {2{acc.cache_wr}};
  assign cache_waddr = '{acc.cache_wr_row, acc.cache_wr_row};
  assign cache_wdata = '{acc.cache_wr_data, acc.cache_wr_data};

  assign cache_re[0]    = (acc.rd1 && acc.rd1_src == SRC_CACHE) || acc.evict_rd;
  assign cache_re[1]    = acc.rd2 && acc.rd2_src == SRC_CACHE;
  assign cache_raddr[0] = acc.evict_rd ? acc.evict_row : acc.rd1_row;
  assign cache_raddr[1] = acc.rd2_row;
  assign evict_data     = cache_rdata[0];

  always_ff @(posedge clk) begin
    if (!rst_n) begin
      vld1_q  <= '0;
      vld2_q  <= '0;
      evict_q <= '0;
    end else begin
      for (int i = L; i > 0; i--) begin
        vld1_q[i]  <= vld1_q[i-1];
        vld2_q[i]  <= vld2_q[i-1];
        evict_q[i] <= evict_q[i-1];
      end
      vld1_q[0]  <= acc.rd1;
      vld2_q[0]  <= acc.rd2;
      evict_q[0] <= acc.evict_rd;
    end
  end

  always_ff @(posedge clk) begin
    for (int i = L; i > 0; i--) begin
      bnk1_q[i] <= bnk1_q[i-1];
      bnk2_q[i] <= bnk2_q[i-1];
      src1_q[i] <= src1_q[i-1];
      src2_q[i] <= src2_q[i-1];
    end
    bnk1_q[0] <= acc.rd1_bank;
    bnk2_q[0] <= acc.rd2_bank;
    src1_q[0] <= acc.rd1_src;
    src2_q[0] <= acc.rd2_src;
  end

  assign resp.resp_valid1 = vld1_q[L] || evict_q[L];
  assign resp.resp_evict  = evict_q[L];
  assign resp.resp_data1  = (evict_q[L] || src1_q[L] == SRC_CACHE) ? cache_rdata[0]
                                                                   : bank_rdata1[bnk1_q[L]];
  assign resp.resp_valid2 = vld2_q[L];
  assign resp.resp_data2  = (src2_q[L] == SRC_CACHE) ? cache_rdata[1] : bank_rdata2[bnk2_q[L]];

endmodule

`default_nettype wire

// File: design/mpm_ram.sv
`default_nettype none

module mpm_ram #(
  parameter int DEPTH = 64,
  parameter int WIDTH = 32,
  parameter int READ_DELAY = 2,
  localparam int AW = $clog2(DEPTH)
) (
  input  wire              clk,
  input  wire              we,
  input  wire  [AW-1:0]    waddr,
  input  wire  [WIDTH-1:0] wdata,
  input  wire              re,
  input  wire  [AW-1:0]    raddr,
  output logic [WIDTH-1:0] rdata
);

  logic [WIDTH-1:0] mem [DEPTH];
  logic [WIDTH-1:0] pipe [READ_DELAY];

  always_ff @(posedge clk) begin
    if (we) begin
      mem[waddr] <= wdata;
    end
  end

  // A read in the same cycle as a write to that row sees the old word.
  always_ff @(posedge clk) begin
    if (re) begin
      pipe[0] <= mem[raddr];
    end
    for (int i = 1; i < READ_DELAY; i++) begin
      pipe[i] <= pipe[i-1];
    end
  end

  assign rdata = pipe[READ_DELAY-1];

endmodule

`default_nettype wire

// File: design/mpm_read_return.sv
`default_nettype none

module mpm_read_return #(
  parameter int WIDTH = 32
) (
  input  wire              clk,
  input  wire              rst_n,
  mpm_resp_if.sink         resp,
  output logic             rd_valid1,
  output logic [WIDTH-1:0] rd_data1,
  output logic             rd_valid2,
  output logic [WIDTH-1:0] rd_data2
);

  always_ff @(posedge clk) begin
    if (!rst_n) begin
      rd_valid1 <= 1'b0;
      rd_valid2 <= 1'b0;
    end else begin
      rd_valid1 <= resp.resp_valid1 && !resp.resp_evict; // Write-back words stay internal.
      rd_valid2 <= resp.resp_valid2;
    end
  end

  // Data only moves when a word comes back, so it holds between reads.
  always_ff @(posedge clk) begin
    if (resp.resp_valid1) begin
      rd_data1 <= resp.resp_data1;
    end
    if (resp.resp_valid2) begin
      rd_data2 <= resp.resp_data2;
    end
  end

endmodule

`default_nettype wire

// File: design/mpm_resp_if.sv
`default_nettype none

interface mpm_resp_if #(
  parameter int WIDTH = 32
) ();

  logic             resp_valid1;
  logic [WIDTH-1:0] resp_data1;
  logic             resp_evict; // Port 1 word belongs to a cache write-back.
  logic             resp_valid2;
  logic [WIDTH-1:0] resp_data2;

  modport source (
    output resp_valid1, resp_data1, resp_evict, resp_valid2, resp_data2
  );

  modport sink (
    input resp_valid1, resp_data1, resp_evict, resp_valid2, resp_data2
  );

endinterface

`default_nettype wire

// File: design/mpm_top.sv
`default_nettype none

module mpm_top #(
  parameter int WIDTH = 32,
  parameter int NUMVBNK = 8,
  parameter int NUMVROW = 64,
  parameter int READ_DELAY = 2,
  localparam int BVB = $clog2(NUMVBNK),
  localparam int BVR = $clog2(NUMVROW)
) (
  input  wire              clk,
  input  wire              rst_n,
  input  wire              req_valid,
  output logic             req_ready,
  input  wire              rd_en1,
  input  wire  [BVB-1:0]   rd_bank1,
  input  wire  [BVR-1:0]   rd_row1,
  input  wire              rd_en2,
  input  wire  [BVB-1:0]   rd_bank2,
  input  wire  [BVR-1:0]   rd_row2,
  input  wire              wr_en1,
  input  wire  [BVB-1:0]   wr_bank1,
  input  wire  [BVR-1:0]   wr_row1,
  input  wire  [WIDTH-1:0] wr_data1,
  input  wire              wr_en2,
  input  wire  [BVB-1:0]   wr_bank2,
  input  wire  [BVR-1:0]   wr_row2,
  input  wire  [WIDTH-1:0] wr_data2,
  output logic             rd_valid1,
  output logic [WIDTH-1:0] rd_data1,
  output logic             rd_valid2,
  output logic [WIDTH-1:0] rd_data2
);

  logic [NUMVBNK-1:0] bank_we;
  logic [BVR-1:0]     bank_waddr [NUMVBNK];
  logic [WIDTH-1:0]   bank_wdata [NUMVBNK];
  logic [NUMVBNK-1:0] bank_re1;
  logic [NUMVBNK-1:0] bank_re2;
  logic [BVR-1:0]     bank_raddr1;
  logic [BVR-1:0]     bank_raddr2;
  logic [WIDTH-1:0]   bank_rdata1 [NUMVBNK];
  logic [WIDTH-1:0]   bank_rdata2 [NUMVBNK];
  logic [1:0]         cache_we;
  logic [BVR-1:0]     cache_waddr [2];
  logic [WIDTH-1:0]   cache_wdata [2];
  logic [1:0]         cache_re;
  logic [BVR-1:0]     cache_raddr [2];
  logic [WIDTH-1:0]   cache_rdata [2];
  logic [WIDTH-1:0]   evict_data;

  mpm_access_if #(.WIDTH(WIDTH), .NUMVBNK(NUMVBNK), .NUMVROW(NUMVROW)) acc_if ();
  mpm_resp_if #(.WIDTH(WIDTH)) resp_if ();

  mpm_map_stage #(
    .WIDTH(WIDTH), .NUMVBNK(NUMVBNK), .NUMVROW(NUMVROW), .READ_DELAY(READ_DELAY)
  ) u_map_stage (
    .clk, .rst_n, .req_valid, .req_ready,
    .rd_en1, .rd_bank1, .rd_row1, .rd_en2, .rd_bank2, .rd_row2,
    .wr_en1, .wr_bank1, .wr_row1, .wr_data1, .wr_en2, .wr_bank2, .wr_row2, .wr_data2,
    .acc(acc_if), .evict_data
  );

  mpm_port_mux #(
    .WIDTH(WIDTH), .NUMVBNK(NUMVBNK), .NUMVROW(NUMVROW), .READ_DELAY(READ_DELAY)
  ) u_port_mux (
    .clk, .rst_n, .acc(acc_if), .resp(resp_if),
    .bank_we, .bank_waddr, .bank_wdata, .bank_re1, .bank_re2,
    .bank_raddr1, .bank_raddr2, .bank_rdata1, .bank_rdata2,
    .cache_we, .cache_waddr, .cache_wdata, .cache_re, .cache_raddr, .cache_rdata,
    .evict_data
  );

  mpm_read_return #(.WIDTH(WIDTH)) u_read_return (
    .clk, .rst_n, .resp(resp_if), .rd_valid1, .rd_data1, .rd_valid2, .rd_data2
  );

  // Each bank is two copies sharing the write, one per read port.
  for (genvar b = 0; b < NUMVBNK; b++) begin : g_bank
    mpm_ram #(.DEPTH(NUMVROW), .WIDTH(WIDTH), .READ_DELAY(READ_DELAY)) u_ram1 (
      .clk, .we(bank_we[b]), .waddr(bank_waddr[b]), .wdata(bank_wdata[b]),
      .re(bank_re1[b]), .raddr(bank_raddr1), .rdata(bank_rdata1[b])
    );
    mpm_ram #(.DEPTH(NUMVROW), .WIDTH(WIDTH), .READ_DELAY(READ_DELAY)) u_ram2 (
      .clk, .we(bank_we[b]), .waddr(bank_waddr[b]), .wdata(bank_wdata[b]),
      .re(bank_re2[b]), .raddr(bank_raddr2), .rdata(bank_rdata2[b])
    );
  end

  for (genvar c = 0; c < 2; c++) begin : g_cache
    mpm_ram #(.DEPTH(NUMVROW), .WIDTH(WIDTH), .READ_DELAY(READ_DELAY)) u_ram (
      .clk, .we(cache_we[c]), .waddr(cache_waddr[c]), .wdata(cache_wdata[c]),
      .re(cache_re[c]), .raddr(cache_raddr[c]), .rdata(cache_rdata[c])
    );
  end

endmodule

`default_nettype wire

// File: files.f
design/mpm_pkg.sv
design/mpm_access_if.sv
design/mpm_resp_if.sv
design/mpm_ram.sv
design/mpm_map_stage.sv
design/mpm_port_mux.sv
design/mpm_read_return.sv
design/mpm_top.sv
tests/mpm_tb.sv

// File: tests/mpm_tb.sv
`default_nettype none

module mpm_tb import mpm_pkg::*; ;

  timeunit 1ns;
  timeprecision 100ps;

  localparam int WIDTH      = 32;
  localparam int NUMVBNK    = 8;
  localparam int NUMVROW    = 64;
  localparam int READ_DELAY = 2;
  localparam int BVB        = $clog2(NUMVBNK);
  localparam int BVR        = $clog2(NUMVROW);
  localparam int TIMEOUT    = 50;

  logic             clk;
  logic             rst_n;
  logic             req_valid;
  logic             req_ready;
  logic             rd_en1;
  logic [BVB-1:0]   rd_bank1;
  logic [BVR-1:0]   rd_row1;
  logic             rd_en2;
  logic [BVB-1:0]   rd_bank2;
  logic [BVR-1:0]   rd_row2;
  logic             wr_en1;
  logic [BVB-1:0]   wr_bank1;
  logic [BVR-1:0]   wr_row1;
  logic [WIDTH-1:0] wr_data1;
  logic             wr_en2;
  logic [BVB-1:0]   wr_bank2;
  logic [BVR-1:0]   wr_row2;
  logic [WIDTH-1:0] wr_data2;
  logic             rd_valid1;
  logic [WIDTH-1:0] rd_data1;
  logic             rd_valid2;
  logic [WIDTH-1:0] rd_data2;

  logic [WIDTH-1:0] model [int]; // Latest word per bank and row.
  logic [WIDTH-1:0] exp1 [$];
  logic [WIDTH-1:0] exp2 [$];
  string            cur_test;
  int               errors;
  int               checks;
  int               test_err0;
  int               tests_run;
  int               last_stall;

  mpm_top u_mpm_top (
    .clk, .rst_n, .req_valid, .req_ready,
    .rd_en1, .rd_bank1, .rd_row1, .rd_en2, .rd_bank2, .rd_row2,
    .wr_en1, .wr_bank1, .wr_row1, .wr_data1, .wr_en2, .wr_bank2, .wr_row2, .wr_data2,
    .rd_valid1, .rd_data1, .rd_valid2, .rd_data2
  );

  always #4 clk = ~clk;

  task automatic check(input string name, input logic [WIDTH-1:0] expected,
                       input logic [WIDTH-1:0] actual);
    checks++;
    if (actual !== expected) begin
      errors++;
      $display("[FAIL] %s: expected %h, actual %h", name, expected, actual);
    end
  endtask

  task automatic stop_on_timeout(input string what);
    $display("Timeout in %s: %s", cur_test, what);
    $display("Something failed");
    $finish;
  endtask

  function automatic int addr_key(input logic [BVB-1:0] bank, input logic [BVR-1:0] row);
    return int'(bank) * NUMVROW + int'(row);
  endfunction

  function automatic logic [WIDTH-1:0] model_word(input int key);
    if (model.exists(key)) begin
      return model[key];
    end
    return 'x;
  endfunction

  task automatic clear_req();
    req_valid = 1'b0;
    rd_en1    = 1'b0;
    rd_en2    = 1'b0;
    wr_en1    = 1'b0;
    wr_en2    = 1'b0;
    {rd_bank1, rd_row1, rd_bank2, rd_row2} = '0;
    {wr_bank1, wr_row1, wr_data1, wr_bank2, wr_row2, wr_data2} = '0;
  endtask

  task automatic set_read(input int port, input int bank, input int row);
    if (port == 1) begin
      rd_en1   = 1'b1;
      rd_bank1 = BVB'(bank);
      rd_row1  = BVR'(row);
    end else begin
      rd_en2   = 1'b1;
      rd_bank2 = BVB'(bank);
      rd_row2  = BVR'(row);
    end
  endtask

  task automatic set_write(input int port, input int bank, input int row,
                           input logic [WIDTH-1:0] data);
    if (port == 1) begin
      wr_en1   = 1'b1;
      wr_bank1 = BVB'(bank);
      wr_row1  = BVR'(row);
      wr_data1 = data;
    end else begin
      wr_en2   = 1'b1;
      wr_bank2 = BVB'(bank);
      wr_row2  = BVR'(row);
      wr_data2 = data;
    end
  endtask

  // Holds the request until accepted, then updates the model at the accepting edge.
  task automatic send_req();
    int         waited;
    map_state_e st;
    waited    = 0;
    req_valid = 1'b1;
    @(negedge clk);
    while (!req_ready && waited < TIMEOUT) begin
      waited++;
      @(negedge clk);
    end
    if (!req_ready) begin
      st = u_mpm_top.u_map_stage.state;
      stop_on_timeout($sformatf("req_ready stayed low with the map stage in %s", st.name()));
    end
    last_stall = waited;
    @(posedge clk);
    if (rd_en1) begin
      exp1.push_back(model_word(addr_key(rd_bank1, rd_row1)));
    end
    if (rd_en2) begin
      exp2.push_back(model_word(addr_key(rd_bank2, rd_row2)));
    end
    if (wr_en1) begin
      model[addr_key(wr_bank1, wr_row1)] = wr_data1;
    end
    if (wr_en2) begin
      model[addr_key(wr_bank2, wr_row2)] = wr_data2; // Applied last so it wins a shared address.
    end
    #1;
    clear_req();
  endtask

  task automatic wait_reads();
    int waited;
    waited = 0;
    do begin
      @(posedge clk);
      waited++;
    end while ((exp1.size() != 0 || exp2.size() != 0) && waited < TIMEOUT);
    if (exp1.size() != 0 || exp2.size() != 0) begin
      stop_on_timeout("read results never came back");
    end
    #1;
  endtask

  task automatic begin_test(input string name);
    cur_test  = name;
    test_err0 = errors;
  endtask

  task automatic end_test();
    $display("%-20s %s, %0d mismatches", cur_test,
             (errors == test_err0) ? "passed" : "failed", errors - test_err0);
    tests_run++;
  endtask

  // Read results are compared at the falling edge, where the outputs are settled.
  always @(negedge clk) begin
    if (rst_n && rd_valid1) begin
      if (exp1.size() == 0) begin
        errors++;
        $display("Error in %s: rd_valid1 rose with no read outstanding", cur_test);
      end else begin
        check({cur_test, " port 1"}, exp1.pop_front(), rd_data1);
      end
    end
    if (rst_n && rd_valid2) begin
      if (exp2.size() == 0) begin
        errors++;
        $display("Error in %s: rd_valid2 rose with no read outstanding", cur_test);
      end else begin
        check({cur_test, " port 2"}, exp2.pop_front(), rd_data2);
      end
    end
  end

  task automatic reset_state();
    int   lat;
    logic found;
    begin_test("reset_state");
    check({cur_test, " req_ready"}, 1, req_ready);
    check({cur_test, " rd_valid1"}, 0, rd_valid1);
    check({cur_test, " rd_valid2"}, 0, rd_valid2);
    set_write(1, 0, 0, $urandom());
    send_req();
    set_read(1, 0, 0);
    send_req();
    lat   = 0;
    found = 1'b0;
    while (!found && lat < TIMEOUT) begin
      @(negedge clk);
      if (rd_valid1) begin
        found = 1'b1;
      end else begin
        @(posedge clk);
        lat++;
      end
    end
    if (!found) begin
      stop_on_timeout("rd_valid1 never rose");
    end
    check({cur_test, " latency"}, READ_DELAY + 1, lat);
    @(posedge clk);
    #1;
    wait_reads();
    end_test();
  endtask

  task automatic diff_banks();
    begin_test("diff_banks");
    set_write(1, 1, 5, $urandom());
    set_write(2, 2, 5, $urandom());
    send_req();
    set_write(1, 1, 5, $urandom());
    set_write(2, 2, 5, $urandom());
    set_read(1, 1, 5); // Same request as the writes, so the old words come back.
    set_read(2, 2, 5);
    send_req();
    set_read(1, 1, 5);
    set_read(2, 2, 5);
    send_req();
    wait_reads();
    end_test();
  endtask

  task automatic same_bank_conflict();
    begin_test("same_bank_conflict");
    for (int pass = 0; pass < 2; pass++) begin
      set_write(1, 3, 1 + pass, $urandom());
      set_write(2, 3, 2 - pass, $urandom());
      send_req();
      set_read(1, 3, 1);
      set_read(2, 3, 2);
      send_req();
      set_read(1, 3, 2);
      set_read(2, 3, 1);
      send_req();
    end
    wait_reads();
    end_test();
  endtask

  task automatic same_address();
    begin_test("same_address");
    set_write(1, 5, 7, $urandom());
    set_write(2, 5, 7, $urandom());
    send_req();
    set_read(1, 5, 7);
    set_read(2, 5, 7);
    send_req();
    wait_reads();
    end_test();
  endtask

  task automatic eviction();
    begin_test("eviction");
    set_write(1, 1, 4, $urandom());
    set_write(2, 1, 9, $urandom());
    send_req();
    set_write(1, 2, 4, $urandom()); // Row 4 of the cache still belongs to bank 1.
    set_write(2, 2, 10, $urandom());
    send_req();
    check({cur_test, " ready stall"}, 1, last_stall > 0);
    set_read(1, 1, 4);
    set_read(2, 1, 9);
    send_req();
    set_read(1, 2, 4);
    set_read(2, 2, 10);
    send_req();
    wait_reads();
    end_test();
  endtask

  task automatic random_traffic();
    int bank_a;
    int bank_b;
    begin_test("random_traffic");
    for (int r = 0; r < 4; r++) begin
      for (int b = 0; b < NUMVBNK; b += 2) begin
        set_write(1, b, r, $urandom());
        set_write(2, b + 1, r, $urandom());
        send_req();
      end
    end
    for (int n = 0; n < 300; n++) begin
      bank_a = $urandom_range(NUMVBNK - 1, 0);
      bank_b = ($urandom_range(1, 0) == 1) ? bank_a : $urandom_range(NUMVBNK - 1, 0);
      if ($urandom_range(1, 0) == 1) begin
        set_read(1, $urandom_range(NUMVBNK - 1, 0), $urandom_range(3, 0));
      end
      if ($urandom_range(1, 0) == 1) begin
        set_read(2, $urandom_range(NUMVBNK - 1, 0), $urandom_range(3, 0));
      end
      if ($urandom_range(1, 0) == 1) begin
        set_write(1, bank_a, $urandom_range(3, 0), $urandom());
      end
      if ($urandom_range(1, 0) == 1) begin
        set_write(2, bank_b, $urandom_range(3, 0), $urandom());
      end
      send_req();
    end
    wait_reads();
    end_test();
  endtask

  initial begin
    void'($urandom(32'h24ab448c));
    clk        = 1'b0;
    rst_n      = 1'b0;
    errors     = 0;
    checks     = 0;
    tests_run  = 0;
    last_stall = 0;
    cur_test   = "startup";
    clear_req();
    repeat (2) @(posedge clk);
    #1;
    rst_n = 1'b1;
    reset_state();
    diff_banks();
    same_bank_conflict();
    same_address();
    eviction();
    random_traffic();
    $display("%0d tests, %0d checks, %0d errors", tests_run, checks, errors);
    if (errors == 0) begin
      $display("Everything OK");
    end else begin
      $display("Something failed");
    end
    $finish;
  end

endmodule

`default_nettype wire
